//--- compile.f
source/coreTypesPkg.sv
source/memTypesPkg.sv
source/operandBypass.sv
source/loadAddrGen.sv
source/dataTlb.sv
source/loadIssueTop.sv
sim/loadIssueTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= loadIssueTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(BUILD_DIR)

//--- sim/loadIssueTb.sv
`timescale 1ns/10ps

module loadIssueTb;
    import coreTypesPkg::*;
    import memTypesPkg::*;

    localparam int entryCount = 8;
    localparam int cycleLimit = 600;
    localparam int randomCycles = 300;

    logic         Clk = 1'b0;
    logic         arstN;
    logic         stop;
    logic         flush;
    loadIssueT    issue;
    fwdSetT       fwd;
    tlbWriteT     tlbWrite;
    loadBufEntryT loadBuf;

    // Shadow copy of the TLB table
    logic shPresent [entryCount];
    vpnT  shVpn [entryCount];
    ppnT  shPpn [entryCount];
    matT  shMat [entryCount];
    logic shValid [entryCount];

    loadBufEntryT expQ [$];
    string        nameQ [$];
    loadBufEntryT lastExp;
    loadBufEntryT wantEntry;
    string        wantName;
    int           checkCount;
    int           mismatchCount;
    int           timeoutCount;
    int           cycleCount;

    microOpE opPool [9] = '{opLdB, opLdH, opLdW, opLdBU, opLdHU, opPreld, opDbar, opIbar, opNop};
    vpnT vpnPool [6] = '{20'h00012, 20'h00013, 20'h00020, 20'h00050, 20'hFFFFF, 20'h00000};

    loadIssueTop #(.tlbEntries(entryCount)) UUT (
        .Clk      (Clk),
        .arstN    (arstN),
        .stop     (stop),
        .flush    (flush),
        .issue    (issue),
        .fwd      (fwd),
        .tlbWrite (tlbWrite),
        .loadBuf  (loadBuf)
    );

    always #50 Clk = ~Clk;

    function automatic loadBufEntryT refEntry(input loadIssueT it, input fwdSetT fw);
        loadBufEntryT e;
        dataT         base;
        vAddrT        va;
        int           offset;
        int           hitIdx;
        e = '0;
        e.able = it.instAble;
        e.microOp = it.microOp;
        e.wbAble = it.wbAble;
        e.wbTag = it.wbTag;
        e.robPtr = it.robPtr;
        base = it.srcData;
        if (it.srcAble) begin
            if (fw.bru.able && fw.bru.tag == it.srcTag) base = fw.bru.data;
            else if (fw.alu1.able && fw.alu1.tag == it.srcTag) base = fw.alu1.data;
            else if (fw.alu2.able && fw.alu2.tag == it.srcTag) base = fw.alu2.data;
            else if (fw.mlu.able && fw.mlu.tag == it.srcTag) base = fw.mlu.data;
            else if (fw.csr.able && fw.csr.tag == it.srcTag) base = fw.csr.data;
        end
        offset = $signed(it.imm);
        va = base + vAddrT'(offset);
        if (it.instAble && it.microOp != opPreld && it.microOp != opDbar
                && it.microOp != opIbar) begin
            hitIdx = -1;
            for (int i = entryCount - 1; i >= 0; i--) begin
                if (shPresent[i] && shVpn[i] == va[31:12]) hitIdx = i;
            end
            if (hitIdx < 0) begin
                e.trap = 1'b1;
                e.trapCode = trapTlbRefill;
            end else if (!shValid[hitIdx]) begin
                e.trap = 1'b1;
                e.trapCode = trapPageInvalid;
            end else begin
                e.mat = shMat[hitIdx];
                e.pAddr = {shPpn[hitIdx], va[11:0]};
            end
        end
        return e;
    endfunction

    function automatic loadIssueT makeLoad(input microOpE op, input logic srcOn,
            input renameRegT tag, input dataT data, input immT imm, input renameRegT wbTag,
            input robPtrT rob);
        loadIssueT it;
        it = '0;
        it.instAble = 1'b1;
        it.microOp = op;
        it.srcAble = srcOn;
        it.srcTag = tag;
        it.srcData = data;
        it.imm = imm;
        it.wbAble = 1'b1;
        it.wbTag = wbTag;
        it.robPtr = rob;
        return it;
    endfunction

    function automatic fwdBusT randomBus();
        fwdBusT b;
        b.able = 1'($urandom);
        b.tag = renameRegT'($urandom % 4);
        b.data = {vpnPool[$urandom % 6], 12'($urandom)};
        return b;
    endfunction

    task automatic driveCycle(input string name, input loadIssueT it, input fwdSetT fw,
                              input tlbWriteT wr, input logic st, input logic fl);
        loadBufEntryT nextExp;
        int           wi;
        issue = it;
        fwd = fw;
        tlbWrite = wr;
        stop = st;
        flush = fl;
        if (st) nextExp = lastExp;    // Output held
        else if (fl) nextExp = '0;
        else nextExp = refEntry(it, fw);
        expQ.push_back(nextExp);
        nameQ.push_back(name);
        lastExp = nextExp;
        wi = int'(wr.index);
        if (wr.strobe && wi < entryCount) begin    // Lands after this cycle's lookup
            shPresent[wi] = 1'b1;
            shVpn[wi] = wr.vpn;
            shPpn[wi] = wr.ppn;
            shMat[wi] = wr.mat;
            shValid[wi] = wr.valid;
        end
        @(posedge Clk);
        #5;
    endtask

    task automatic issueLoad(input string name, input loadIssueT it, input fwdSetT fw);
        driveCycle(name, it, fw, '0, 1'b0, 1'b0);
    endtask

    task automatic writeTlb(input int idx, input vpnT vpn, input ppnT ppn, input matT mat,
                            input logic valid, input loadIssueT it);
        tlbWriteT wr;
        wr.strobe = 1'b1;
        wr.index = tlbIndexT'(idx);
        wr.vpn = vpn;
        wr.ppn = ppn;
        wr.mat = mat;
        wr.valid = valid;
        driveCycle("tlbWrite", it, '0, wr, 1'b0, 1'b0);
    endtask

    task automatic runDirected();
        fwdSetT    fw;
        loadIssueT ldA;
        loadIssueT ldB;
        // Empty table right after reset
        issueLoad("resetMiss", makeLoad(opLdW, 1'b0, 7'h0, 32'h00000100, 12'h0, 7'h20, 6'd0),
                  '0);
        writeTlb(0, 20'h00012, 20'h80012, 2'd1, 1'b1, '0);
        writeTlb(1, 20'h00013, 20'h9A013, 2'd2, 1'b1, '0);
        writeTlb(2, 20'hFFFFF, 20'h12345, 2'd0, 1'b1, '0);
        writeTlb(3, 20'h00000, 20'h00777, 2'd3, 1'b1, '0);
        writeTlb(4, 20'h00020, 20'h44020, 2'd1, 1'b0, '0);
        writeTlb(5, 20'h00012, 20'h5D012, 2'd2, 1'b1, '0);    // Shadowed by entry 0
        ldA = makeLoad(opLdW, 1'b1, 7'h15, 32'h00012600, 12'h004, 7'h21, 6'd1);
        fw.bru = '{1'b1, 7'h15, 32'h00012100};
        fw.alu1 = '{1'b1, 7'h15, 32'h00012200};
        fw.alu2 = '{1'b1, 7'h15, 32'h00012300};
        fw.mlu = '{1'b1, 7'h15, 32'h00012400};
        fw.csr = '{1'b1, 7'h15, 32'h00012500};
        issueLoad("fwdAllMatch", ldA, fw);
        fw.bru.able = 1'b0;
        issueLoad("fwdAlu1", ldA, fw);
        fw.alu1.tag = 7'h16;
        issueLoad("fwdAlu2", ldA, fw);
        fw.alu2.able = 1'b0;
        issueLoad("fwdMlu", ldA, fw);
        fw.mlu.tag = 7'h00;
        issueLoad("fwdCsr", ldA, fw);
        fw.csr.tag = 7'h14;
        issueLoad("fwdNone", ldA, fw);
        fw.bru.able = 1'b1;
        ldA.srcAble = 1'b0;
        issueLoad("fwdSrcOff", ldA, fw);
        issueLoad("immPositive",
                  makeLoad(opLdB, 1'b0, 7'h0, 32'h00012801, 12'h7FF, 7'h22, 6'd2), '0);
        issueLoad("immNegative",
                  makeLoad(opLdH, 1'b0, 7'h0, 32'h00013010, 12'hF00, 7'h23, 6'd3), '0);
        issueLoad("wrapUp",
                  makeLoad(opLdBU, 1'b0, 7'h0, 32'hFFFFFF00, 12'h7FF, 7'h24, 6'd4), '0);
        issueLoad("wrapDown",
                  makeLoad(opLdHU, 1'b0, 7'h0, 32'h00000010, 12'h800, 7'h25, 6'd5), '0);
        ldB = makeLoad(opLdW, 1'b0, 7'h0, 32'h00020ABC, 12'h000, 7'h26, 6'd6);
        issueLoad("tlbMiss",
                  makeLoad(opLdW, 1'b0, 7'h0, 32'h00050000, 12'h010, 7'h27, 6'd7), '0);
        issueLoad("pageInvalid", ldB, '0);
        writeTlb(4, 20'h00020, 20'h55020, 2'd2, 1'b1, ldB);    // Lookup still sees old entry
        issueLoad("afterRewrite", ldB, '0);
        issueLoad("preld", makeLoad(opPreld, 1'b0, 7'h0, 32'h00050000, 12'h0, 7'h31, 6'd11), '0);
        issueLoad("dbar", makeLoad(opDbar, 1'b0, 7'h0, 32'h00050000, 12'h0, 7'h32, 6'd12), '0);
        issueLoad("ibar", makeLoad(opIbar, 1'b0, 7'h0, 32'h00050000, 12'h0, 7'h33, 6'd13), '0);
        ldA = makeLoad(opLdW, 1'b0, 7'h0, 32'h00013040, 12'h008, 7'h41, 6'd20);
        issueLoad("beforeStop", ldA, '0);
        driveCycle("stopHold", ldB, '0, '0, 1'b1, 1'b0);
        driveCycle("stopHold", ldB, '0, '0, 1'b1, 1'b0);
        driveCycle("stopAndFlush", ldB, '0, '0, 1'b1, 1'b1);
        driveCycle("stopAndFlush", ldA, '0, '0, 1'b1, 1'b1);
        driveCycle("flushOnly", ldB, '0, '0, 1'b0, 1'b1);
        issueLoad("resume", ldB, '0);
        issueLoad("resume", ldA, '0);
    endtask

    task automatic runRandomMix();
        loadIssueT it;
        fwdSetT    fw;
        tlbWriteT  wr;
        for (int n = 0; n < randomCycles; n++) begin
            it.instAble = ($urandom % 8) != 0;
            it.microOp = opPool[$urandom % 9];
            it.srcAble = 1'($urandom);
            it.srcTag = renameRegT'($urandom % 4);
            it.srcData = {vpnPool[$urandom % 6], 12'($urandom)};
            it.imm = immT'($urandom);
            it.wbAble = 1'($urandom);
            it.wbTag = renameRegT'($urandom);
            it.robPtr = robPtrT'($urandom);
            fw.bru = randomBus();
            fw.alu1 = randomBus();
            fw.alu2 = randomBus();
            fw.mlu = randomBus();
            fw.csr = randomBus();
            wr.strobe = ($urandom % 16) == 0;
            wr.index = tlbIndexT'($urandom % 8);
            wr.vpn = vpnPool[$urandom % 6];
            wr.ppn = ppnT'($urandom);
            wr.mat = matT'($urandom);
            wr.valid = ($urandom % 4) != 0;
            driveCycle("randomMix", it, fw, wr, ($urandom % 10) == 0, ($urandom % 16) == 0);
        end
    endtask

    // loadBuf seen at this edge was registered one edge earlier
    always @(posedge Clk) begin
        if (arstN && expQ.size() > 1) begin
            wantEntry = expQ.pop_front();
            wantName = nameQ.pop_front();
            checkCount++;
            assert (loadBuf === wantEntry)
            else begin
                $display("MISMATCH %s: expected %h actual %h", wantName, wantEntry, loadBuf);
                mismatchCount++;
            end
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge Clk);
            cycleCount++;
        end
        timeoutCount = 1;
        $display("Timeout: the run did not end within %0d cycles", cycleLimit);
        $display("checks %0d, mismatches %0d, timeouts %0d", checkCount, mismatchCount,
                 timeoutCount);
        $display("test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hcf8c));
        arstN = 1'b0;
        stop = 1'b0;
        flush = 1'b0;
        issue = '0;
        fwd = '0;
        tlbWrite = '0;
        lastExp = '0;
        checkCount = 0;
        mismatchCount = 0;
        timeoutCount = 0;
        for (int i = 0; i < entryCount; i++) begin
            shPresent[i] = 1'b0;
        end
        repeat (16) @(posedge Clk);
        #5;
        arstN = 1'b1;
        expQ.push_back(lastExp);    // Reset value
        nameQ.push_back("reset");
        runDirected();
        runRandomMix();
        issueLoad("drain", '0, '0);
        issueLoad("drain", '0, '0);
        $display("checks %0d, mismatches %0d, timeouts %0d", checkCount, mismatchCount,
                 timeoutCount);
        if (mismatchCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- source/loadIssueTop.sv
`timescale 1ns/10ps

module loadIssueTop #(
    parameter int tlbEntries = 8
) (
    input  logic                      Clk,
    input  logic                      arstN,
    input  logic                      stop,
    input  logic                      flush,
    input  coreTypesPkg::loadIssueT   issue,
    input  coreTypesPkg::fwdSetT      fwd,
    input  memTypesPkg::tlbWriteT     tlbWrite,
    output memTypesPkg::loadBufEntryT loadBuf
);
    import coreTypesPkg::*;
    import memTypesPkg::*;

    dataT    srcValue;
    logic    tlbAccess;
    vAddrT   tlbVAddr;
    tlbRespT tlbResp;

    operandBypass uBypass (
        .srcAble  (issue.srcAble),
        .srcTag   (issue.srcTag),
        .srcData  (issue.srcData),
        .fwd      (fwd),
        .srcValue (srcValue)
    );

    loadAddrGen uAgu (
        .Clk       (Clk),
        .arstN     (arstN),
        .stop      (stop),
        .flush     (flush),
        .issue     (issue),
        .srcValue  (srcValue),
        .tlbAccess (tlbAccess),
        .tlbVAddr  (tlbVAddr),
        .tlbResp   (tlbResp),
        .loadBuf   (loadBuf)
    );

    dataTlb #(
        .tlbEntries (tlbEntries)
    ) uTlb (
        .Clk      (Clk),
        .arstN    (arstN),
        .stop     (stop),
        .flush    (flush),
        .access   (tlbAccess),
        .vAddr    (tlbVAddr),
        .tlbWrite (tlbWrite),
        .resp     (tlbResp)
    );

endmodule

//--- source/dataTlb.sv
`timescale 1ns/10ps

module dataTlb #(
    parameter int tlbEntries = 8
) (
    input  logic                  Clk,
    input  logic                  arstN,
    input  logic                  stop,
    input  logic                  flush,
    input  logic                  access,
    input  memTypesPkg::vAddrT    vAddr,
    input  memTypesPkg::tlbWriteT tlbWrite,
    output memTypesPkg::tlbRespT  resp
);
    import memTypesPkg::*;

    typedef struct packed {
        vpnT  vpn;
        ppnT  ppn;
        matT  mat;
        logic valid;    // Page valid, not slot occupancy
    } tlbLineT;

    logic [tlbEntries-1:0] present;
    tlbLineT               lines [tlbEntries];

    vpnT     lookupVpn;
    logic    hitFound;
    tlbLineT hitLine;
    tlbRespT nextResp;
    tlbRespT respQ;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            present <= '0;
        end else begin
            for (int i = 0; i < tlbEntries; i++) begin
                if (tlbWrite.strobe && (tlbWrite.index == tlbIndexT'(i))) begin
                    present[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        for (int i = 0; i < tlbEntries; i++) begin
            if (tlbWrite.strobe && (tlbWrite.index == tlbIndexT'(i))) begin
                lines[i].vpn   <= tlbWrite.vpn;
                lines[i].ppn   <= tlbWrite.ppn;
                lines[i].mat   <= tlbWrite.mat;
                lines[i].valid <= tlbWrite.valid;
            end
        end
    end

    assign lookupVpn = vAddr[31:pageBits];

    // Lowest index wins on multiple hits
    always_comb begin
        hitFound = 1'b0;
        hitLine  = '0;
        for (int i = 0; i < tlbEntries; i++) begin
            if (!hitFound && present[i] && (lines[i].vpn == lookupVpn)) begin
                hitFound = 1'b1;
                hitLine  = lines[i];
            end
        end
    end

    always_comb begin
        nextResp = '0;
        if (access) begin
            if (!hitFound) begin
                nextResp.trap     = 1'b1;
                nextResp.trapCode = trapTlbRefill;
            end else if (!hitLine.valid) begin
                nextResp.trap     = 1'b1;
                nextResp.trapCode = trapPageInvalid;
            end else begin
                nextResp.trapCode = trapNone;
                nextResp.mat      = hitLine.mat;
                nextResp.pAddr    = {hitLine.ppn, vAddr[pageBits-1:0]};
            end
        end
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            respQ <= '0;
        end else if (stop) begin
            respQ <= respQ;
        end else if (flush) begin
            respQ <= '0;
        end else begin
            respQ <= nextResp;
        end
    end

    assign resp = respQ;

endmodule

//--- source/loadAddrGen.sv
`timescale 1ns/10ps

module loadAddrGen (
    input  logic                       Clk,
    input  logic                       arstN,
    input  logic                       stop,
    input  logic                       flush,
    input  coreTypesPkg::loadIssueT    issue,
    input  coreTypesPkg::dataT         srcValue,
    output logic                       tlbAccess,
    output memTypesPkg::vAddrT         tlbVAddr,
    input  memTypesPkg::tlbRespT       tlbResp,
    output memTypesPkg::loadBufEntryT  loadBuf
);
    import coreTypesPkg::*;
    import memTypesPkg::*;

    typedef struct packed {
        logic      able;
        microOpE   microOp;
        logic      wbAble;
        renameRegT wbTag;
        robPtrT    robPtr;
    } metaT;

    metaT  metaQ;
    logic  noAccess;
    vAddrT immExt;

    // Barriers and preload skip translation
    assign noAccess  = issue.microOp inside {opPreld, opDbar, opIbar};
    assign tlbAccess = issue.instAble && !noAccess;

    assign immExt   = {{(32 - $bits(immT)){issue.imm[$bits(immT)-1]}}, issue.imm};
    assign tlbVAddr = srcValue + immExt;    // Wraps modulo 2^32

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            metaQ <= '0;
        end else if (stop) begin
            metaQ <= metaQ;    // Stop wins over flush
        end else if (flush) begin
            metaQ <= '0;
        end else begin
            metaQ.able    <= issue.instAble;
            metaQ.microOp <= issue.microOp;
            metaQ.wbAble  <= issue.wbAble;
            metaQ.wbTag   <= issue.wbTag;
            metaQ.robPtr  <= issue.robPtr;
        end
    end

    // TLB response is registered in step with metaQ
    always_comb begin
        loadBuf.able     = metaQ.able;
        loadBuf.microOp  = metaQ.microOp;
        loadBuf.mat      = tlbResp.mat;
        loadBuf.pAddr    = tlbResp.pAddr;
        loadBuf.trap     = tlbResp.trap;
        loadBuf.trapCode = tlbResp.trapCode;
        loadBuf.wbAble   = metaQ.wbAble;
        loadBuf.wbTag    = metaQ.wbTag;
        loadBuf.robPtr   = metaQ.robPtr;
    end

endmodule

//--- source/operandBypass.sv
`timescale 1ns/10ps

module operandBypass (
    input  logic                    srcAble,
    input  coreTypesPkg::renameRegT srcTag,
    input  coreTypesPkg::dataT      srcData,
    input  coreTypesPkg::fwdSetT    fwd,
    output coreTypesPkg::dataT      srcValue
);
    import coreTypesPkg::*;

    localparam int busCount = 5;

    fwdBusT              busList [busCount];
    logic [busCount-1:0] busHit;

    // Index 0 has the highest priority
    assign busList = '{fwd.bru, fwd.alu1, fwd.alu2, fwd.mlu, fwd.csr};

    always_comb begin
        for (int i = 0; i < busCount; i++) begin
            busHit[i] = srcAble && busList[i].able && (busList[i].tag == srcTag);
        end
    end

    // Walk from lowest priority up so the freshest match overrides
    always_comb begin
        srcValue = srcData;
        for (int i = busCount - 1; i >= 0; i--) begin
            if (busHit[i]) begin
                srcValue = busList[i].data;
            end
        end
    end

endmodule

//--- source/memTypesPkg.sv
package memTypesPkg;

    localparam int pageBits = 12;    // 4 KB pages

    typedef logic [31:0] vAddrT;
    typedef logic [31:0] pAddrT;
    typedef logic [19:0] vpnT;
    typedef logic [19:0] ppnT;
    typedef logic [1:0]  matT;
    typedef logic [6:0]  trapCodeT;
    typedef logic [3:0]  tlbIndexT;

    localparam trapCodeT trapNone        = 7'h00;
    localparam trapCodeT trapPageInvalid = 7'h01;    // PIL
    localparam trapCodeT trapTlbRefill   = 7'h3f;

    typedef struct packed {
        logic     strobe;
        tlbIndexT index;
        vpnT      vpn;
        ppnT      ppn;
        matT      mat;
        logic     valid;
    } tlbWriteT;

    typedef struct packed {
        logic     trap;
        trapCodeT trapCode;
        matT      mat;
        pAddrT    pAddr;
    } tlbRespT;

    typedef struct packed {
        logic                  able;
        coreTypesPkg::microOpE microOp;
        matT                   mat;
        pAddrT                 pAddr;
        logic                  trap;
        trapCodeT              trapCode;
        logic                  wbAble;
        coreTypesPkg::renameRegT wbTag;
        coreTypesPkg::robPtrT  robPtr;
    } loadBufEntryT;

endpackage

//--- source/coreTypesPkg.sv
package coreTypesPkg;

    typedef logic [31:0] dataT;
    typedef logic [6:0]  renameRegT;
    typedef logic [5:0]  robPtrT;
    typedef logic [11:0] immT;

    typedef enum logic [7:0] {
        opNop   = 8'h00,
        opLdB   = 8'h01,
        opLdH   = 8'h02,
        opLdW   = 8'h03,
        opLdBU  = 8'h04,
        opLdHU  = 8'h05,
        opPreld = 8'h06,    // Cache hint only
        opDbar  = 8'h07,
        opIbar  = 8'h08
    } microOpE;

    // One result bus from an execution unit
    typedef struct packed {
        logic      able;
        renameRegT tag;
        dataT      data;
    } fwdBusT;

    typedef struct packed {
        fwdBusT bru;
        fwdBusT alu1;
        fwdBusT alu2;
        fwdBusT mlu;
        fwdBusT csr;
    } fwdSetT;

    typedef struct packed {
        logic      instAble;
        microOpE   microOp;
        logic      srcAble;
        renameRegT srcTag;
        dataT      srcData;    // Register file read value
        immT       imm;
        logic      wbAble;
        renameRegT wbTag;
        robPtrT    robPtr;
    } loadIssueT;

endpackage
